// File: hw/sys_defines.svh
/* System housekeeping constants
   Data widths, debounce timing and the 720p power-up video timing */

`ifndef SYS_DEFINES_SVH
`define SYS_DEFINES_SVH

// Data path widths
`define SYS_AUDIO_W  16
`define SYS_TIMING_W 12

// Debounce history length and default slow-tick divider
`define SYS_DEB_SAMPLES     8
`define SYS_DEB_DIV_DEFAULT 100000

// 1280x720@60 CEA timing held until the host sends its own
`define SYS_RST_WIDTH  1280
`define SYS_RST_HFP    110
`define SYS_RST_HS     40
`define SYS_RST_HBP    220
`define SYS_RST_HEIGHT 720
`define SYS_RST_VFP    5
`define SYS_RST_VS     5
`define SYS_RST_VBP    20

`endif

// File: hw/sys_pkg.sv
/* System housekeeping types
   Host port, configuration registers, audio and LED bundles */

`include "sys_defines.svh"

package sys_pkg;

	// Host parallel I/O port as seen by the FPGA
	typedef struct packed {
		logic        uio;
		logic        clk;
		logic [15:0] din;
	} host_bus_t;

	typedef struct packed {
		logic dvi_mode;
		logic audio_96k;
		logic ypbpr_en;
		logic csync;
		logic vga_scaler;
		logic got;
	} host_cfg_t;

	typedef struct packed {
		logic [`SYS_TIMING_W-1:0] width;
		logic [`SYS_TIMING_W-1:0] hfp;
		logic [`SYS_TIMING_W-1:0] hs;
		logic [`SYS_TIMING_W-1:0] hbp;
		logic [`SYS_TIMING_W-1:0] height;
		logic [`SYS_TIMING_W-1:0] vfp;
		logic [`SYS_TIMING_W-1:0] vs;
		logic [`SYS_TIMING_W-1:0] vbp;
	} video_timing_t;

	typedef struct packed {
		logic [7:0] overtake;
		logic [7:0] state;
	} led_ctl_t;

	typedef struct packed {
		logic       mute;
		logic [3:0] shift;
	} vol_att_t;

	// Core audio with a mix select for the amount of stereo cross-feed
	typedef struct packed {
		logic signed [`SYS_AUDIO_W-1:0] left;
		logic signed [`SYS_AUDIO_W-1:0] right;
		logic                           is_signed;
		logic [1:0]                     mix;
	} audio_in_t;

	typedef struct packed {
		logic       user;
		logic [1:0] power;
		logic [1:0] disk;
	} led_src_t;

	typedef enum logic [7:0] {
		CMD_CFG    = 8'h01,
		CMD_TIMING = 8'h20,
		CMD_LED    = 8'h25,
		CMD_VOL    = 8'h26
	} host_cmd_e;

endpackage

// File: hw/btn_debounce.sv
/* Button debouncer
   Samples the user and OSD buttons on a slow tick with 8-sample hysteresis */

`timescale 1ns/1ps
`include "sys_defines.svh"

module btn_debounce #(
	parameter int deb_div = `SYS_DEB_DIV_DEFAULT
) (
	input  logic       FPGA_CLK2_50,
	input  logic       resetd,
	input  logic       btn_user_n,
	input  logic       btn_osd_n,
	input  logic [1:0] key,
	output logic       btn_user,
	output logic       btn_osd
);

	localparam int DIV_W = $clog2(deb_div + 1);

	logic [DIV_W-1:0]                       div;
	logic [1:0]                             pressed;
	logic [1:0][`SYS_DEB_SAMPLES-1:0]       hist;
	logic [1:0]                             level;

	// Board key and header button are wired-or and both active low
	assign pressed = {~btn_user_n | ~key[1], ~btn_osd_n | ~key[0]};

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			div   <= '0;
			hist  <= '0;
			level <= '0;
		end else begin
			div <= (div == DIV_W'(deb_div)) ? '0 : div + 1'b1;
			if (div == '0) begin
				for (int i = 0; i < 2; i++) begin
					hist[i] <= {hist[i][`SYS_DEB_SAMPLES-2:0], pressed[i]};
					// Judge on the history before this sample
					if (&hist[i])
						level[i] <= 1'b1;
					else if (~|hist[i])
						level[i] <= 1'b0;
				end
			end
		end
	end

	assign btn_user = level[1];
	assign btn_osd  = level[0];

endmodule

// File: hw/host_io_decoder.sv
/* Host I/O command decoder
   Synchronizes the host toggle line, acknowledges it and writes the command registers */

`timescale 1ns/1ps
`include "sys_defines.svh"

module host_io_decoder (
	input  logic                  FPGA_CLK2_50,
	input  logic                  resetd,
	input  sys_pkg::host_bus_t    host,
	output logic                  io_ack,
	output sys_pkg::host_cfg_t    cfg,
	output sys_pkg::video_timing_t timing,
	output sys_pkg::led_ctl_t     led_ctl,
	output sys_pkg::vol_att_t     vol_att
);

	import sys_pkg::*;

	localparam logic [3:0] TIMING_WORDS = 4'd8;

	logic      clk_meta;
	logic      clk_sync;
	logic      rack;
	logic      io_strobe;
	logic      pending;
	host_cmd_e cmd;
	logic [3:0] word_cnt;

	// ============================================================
	// Toggle line handshake
	// ============================================================

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			clk_meta <= 1'b0;
			clk_sync <= 1'b0;
			rack     <= 1'b0;
			io_ack   <= 1'b0;
		end else begin
			clk_meta <= host.clk;
			clk_sync <= clk_meta;
			rack     <= clk_sync;
			io_ack   <= rack;
		end
	end

	// Pulse for one cycle on the rising toggle, two cycles before io_ack
	assign io_strobe = clk_sync & ~rack;

	// ============================================================
	// Command and data words
	// ============================================================

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			pending  <= 1'b0;
			cmd      <= host_cmd_e'(8'h00);
			word_cnt <= '0;
			cfg      <= '0;
			timing   <= '{
				width:  `SYS_TIMING_W'(`SYS_RST_WIDTH),
				hfp:    `SYS_TIMING_W'(`SYS_RST_HFP),
				hs:     `SYS_TIMING_W'(`SYS_RST_HS),
				hbp:    `SYS_TIMING_W'(`SYS_RST_HBP),
				height: `SYS_TIMING_W'(`SYS_RST_HEIGHT),
				vfp:    `SYS_TIMING_W'(`SYS_RST_VFP),
				vs:     `SYS_TIMING_W'(`SYS_RST_VS),
				vbp:    `SYS_TIMING_W'(`SYS_RST_VBP)
			};
			led_ctl  <= '0;
			vol_att  <= '0;
		end else if (!host.uio) begin
			pending <= 1'b0;
		end else if (io_strobe) begin
			if (!pending) begin
				// First word of a transaction is the opcode
				pending  <= 1'b1;
				cmd      <= host_cmd_e'(host.din[7:0]);
				word_cnt <= '0;
			end else begin
				case (cmd)
					CMD_CFG: begin
						cfg.dvi_mode   <= host.din[7];
						cfg.audio_96k  <= host.din[6];
						cfg.ypbpr_en   <= host.din[5];
						cfg.csync      <= host.din[3];
						cfg.vga_scaler <= host.din[2];
						cfg.got        <= 1'b1;
					end
					CMD_TIMING: begin
						// Extra words past vbp are dropped
						if (word_cnt < TIMING_WORDS) begin
							word_cnt <= word_cnt + 1'b1;
							case (word_cnt[2:0])
								3'd0: timing.width  <= host.din[`SYS_TIMING_W-1:0];
								3'd1: timing.hfp    <= host.din[`SYS_TIMING_W-1:0];
								3'd2: timing.hs     <= host.din[`SYS_TIMING_W-1:0];
								3'd3: timing.hbp    <= host.din[`SYS_TIMING_W-1:0];
								3'd4: timing.height <= host.din[`SYS_TIMING_W-1:0];
								3'd5: timing.vfp    <= host.din[`SYS_TIMING_W-1:0];
								3'd6: timing.vs     <= host.din[`SYS_TIMING_W-1:0];
								default: timing.vbp <= host.din[`SYS_TIMING_W-1:0];
							endcase
						end
					end
					CMD_LED: led_ctl <= host.din;
					CMD_VOL: vol_att <= host.din[4:0];
					default: ;
				endcase
			end
		end
	end

endmodule

// File: hw/audio_mixer.sv
/* Audio mixer
   Stereo cross-feed followed by mute and volume attenuation, two stages */

`timescale 1ns/1ps
`include "sys_defines.svh"

module audio_mixer (
	input  logic                    FPGA_CLK2_50,
	input  logic                    resetd,
	input  sys_pkg::audio_in_t      audio_src,
	input  sys_pkg::vol_att_t       vol_att,
	output logic [`SYS_AUDIO_W-1:0] audio_l,
	output logic [`SYS_AUDIO_W-1:0] audio_r
);

	localparam int AW = `SYS_AUDIO_W;

	logic [AW-1:0] mix_l;
	logic [AW-1:0] mix_r;
	logic          mix_signed;

	// Arithmetic shift for signed samples and logical shift on the raw pattern otherwise
	function automatic logic [AW-1:0] shift_r(input logic [AW-1:0] v,
		input logic [3:0] n, input logic sgn);
		if (sgn)
			shift_r = $signed(v) >>> n;
		else
			shift_r = v >> n;
	endfunction

	function automatic logic [AW-1:0] cross_mix(input logic [AW-1:0] own,
		input logic [AW-1:0] other, input logic [1:0] mix, input logic sgn);
		case (mix)
			2'd0: cross_mix = own;
			2'd1: cross_mix = own - shift_r(own, 4'd3, sgn) + shift_r(other, 4'd3, sgn);
			2'd2: cross_mix = own - shift_r(own, 4'd2, sgn) + shift_r(other, 4'd2, sgn);
			default: cross_mix = shift_r(own, 4'd1, sgn) + shift_r(other, 4'd1, sgn);
		endcase
	endfunction

	// ============================================================
	// Stage 1 channel mix
	// ============================================================

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			mix_l      <= '0;
			mix_r      <= '0;
			mix_signed <= 1'b0;
		end else begin
			mix_l      <= cross_mix(audio_src.left, audio_src.right, audio_src.mix,
				audio_src.is_signed);
			mix_r      <= cross_mix(audio_src.right, audio_src.left, audio_src.mix,
				audio_src.is_signed);
			mix_signed <= audio_src.is_signed;
		end
	end

	// ============================================================
	// Stage 2 mute and attenuation
	// ============================================================

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			audio_l <= '0;
			audio_r <= '0;
		end else if (vol_att.mute) begin
			audio_l <= '0;
			audio_r <= '0;
		end else begin
			audio_l <= shift_r(mix_l, vol_att.shift, mix_signed);
			audio_r <= shift_r(mix_r, vol_att.shift, mix_signed);
		end
	end

endmodule

// File: hw/led_driver.sv
/* LED driver
   Status LED levels and the host override on the board LEDs */

`timescale 1ns/1ps

module led_driver (
	input  sys_pkg::led_src_t led_src,
	input  sys_pkg::led_ctl_t led_ctl,
	output logic              led_power,
	output logic              led_hdd,
	output logic              led_user,
	output logic [7:0]        led
);

	logic [7:0] led_default;

	// Power LED stays lit unless the core takes control of it
	assign led_power = led_src.power[1] ? led_src.power[0] : 1'b1;
	assign led_hdd   = led_src.disk[0];
	assign led_user  = led_src.user;

	assign led_default = {3'b000, led_power, 1'b0, led_hdd, 1'b0, led_user};

	// Host override bit by bit
	assign led = (led_ctl.overtake & led_ctl.state) | (~led_ctl.overtake & led_default);

endmodule

// File: hw/sys_core.sv
/* System housekeeping top
   Buttons, host command registers, audio mixing and LEDs on one clock */

`timescale 1ns/1ps
`include "sys_defines.svh"

module sys_core #(
	parameter int deb_div = `SYS_DEB_DIV_DEFAULT
) (
	input  logic                    FPGA_CLK2_50,
	input  logic                    resetd,
	input  sys_pkg::host_bus_t      host,
	output logic                    io_ack,
	input  logic                    btn_user_n,
	input  logic                    btn_osd_n,
	input  logic [1:0]              key,
	output logic                    btn_user,
	output logic                    btn_osd,
	input  sys_pkg::audio_in_t      audio_src,
	output logic [`SYS_AUDIO_W-1:0] audio_l,
	output logic [`SYS_AUDIO_W-1:0] audio_r,
	input  sys_pkg::led_src_t       led_src,
	output logic                    led_power,
	output logic                    led_hdd,
	output logic                    led_user,
	output logic [7:0]              led,
	output sys_pkg::host_cfg_t      cfg,
	output sys_pkg::video_timing_t  timing
);

	import sys_pkg::*;

	led_ctl_t led_ctl;
	vol_att_t vol_att;

	btn_debounce #(
		.deb_div(deb_div)
	) i_btn_debounce (
		.FPGA_CLK2_50(FPGA_CLK2_50),
		.resetd      (resetd),
		.btn_user_n  (btn_user_n),
		.btn_osd_n   (btn_osd_n),
		.key         (key),
		.btn_user    (btn_user),
		.btn_osd     (btn_osd)
	);

	host_io_decoder i_host_io_decoder (
		.FPGA_CLK2_50(FPGA_CLK2_50),
		.resetd      (resetd),
		.host        (host),
		.io_ack      (io_ack),
		.cfg         (cfg),
		.timing      (timing),
		.led_ctl     (led_ctl),
		.vol_att     (vol_att)
	);

	audio_mixer i_audio_mixer (
		.FPGA_CLK2_50(FPGA_CLK2_50),
		.resetd      (resetd),
		.audio_src   (audio_src),
		.vol_att     (vol_att),
		.audio_l     (audio_l),
		.audio_r     (audio_r)
	);

	led_driver i_led_driver (
		.led_src  (led_src),
		.led_ctl  (led_ctl),
		.led_power(led_power),
		.led_hdd  (led_hdd),
		.led_user (led_user),
		.led      (led)
	);

endmodule

// File: verification/sys_core_tb.sv
/* Testbench for the system housekeeping top
   Random host, audio, LED and button stimulus checked against reference models */

`timescale 1ns/1ps
`include "sys_defines.svh"

module sys_core_tb;

	import sys_pkg::*;

	localparam int DEB_DIV = 3;
	// Phases add up to roughly 4000 to 5000 cycles
	localparam int MAX_CYCLES = 20000;

	logic          FPGA_CLK2_50;
	logic          resetd;
	host_bus_t     host;
	logic          io_ack;
	logic          btn_user_n;
	logic          btn_osd_n;
	logic [1:0]    key;
	logic          btn_user;
	logic          btn_osd;
	audio_in_t     audio_src;
	logic [15:0]   audio_l;
	logic [15:0]   audio_r;
	led_src_t      led_src;
	logic          led_power;
	logic          led_hdd;
	logic          led_user;
	logic [7:0]    led;
	host_cfg_t     cfg;
	video_timing_t timing;

	string         test_name = "reset";
	int            cycles = 0;

	// Reference model state advanced on each falling edge
	logic          valid = 1'b0;
	logic [3:0]    clk_q;
	logic          m_pending;
	logic [7:0]    m_cmd;
	int            m_cnt;
	logic [5:0]    m_cfg;
	logic [11:0]   m_tim [8];
	logic [15:0]   m_led;
	logic [4:0]    m_vol;
	logic [15:0]   m_mix_l;
	logic [15:0]   m_mix_r;
	logic          m_mix_sgn;
	logic [15:0]   m_out_l;
	logic [15:0]   m_out_r;
	int            deb_cnt;
	logic [7:0]    deb_hist [2];
	logic [1:0]    deb_level;

	sys_core #(.deb_div(DEB_DIV)) i_dut (.*);

	initial begin
		FPGA_CLK2_50 = 1'b0;
		forever #20 FPGA_CLK2_50 = ~FPGA_CLK2_50;
	end

	always @(posedge FPGA_CLK2_50) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("Verification failed");
			$fatal(1);
		end
	end

	task automatic check_value(input string what, input logic [127:0] expected,
		input logic [127:0] actual);
		if (actual !== expected) begin
			$display("** Error [%s] %s: expected %0h, actual %0h", test_name, what,
				expected, actual);
			$display("Verification failed");
			$fatal(1);
		end
	endtask

	// Sign or zero extend before the shift
	function automatic logic [15:0] shift_right(input logic [15:0] v, input int n,
		input logic sgn);
		logic [31:0] ext;
		ext = sgn ? {{16{v[15]}}, v} : {16'h0000, v};
		ext = ext >> n;
		return ext[15:0];
	endfunction

	function automatic logic [15:0] mix_channel(input logic [15:0] own,
		input logic [15:0] other, input logic [1:0] mix, input logic sgn);
		case (mix)
			2'd0: return own;
			2'd1: return own - shift_right(own, 3, sgn) + shift_right(other, 3, sgn);
			2'd2: return own - shift_right(own, 2, sgn) + shift_right(other, 2, sgn);
			default: return shift_right(own, 1, sgn) + shift_right(other, 1, sgn);
		endcase
	endfunction

	// ============================================================
	// Per-cycle checks and model update
	// ============================================================

	always @(negedge FPGA_CLK2_50) begin
		logic       power_lit;
		logic [7:0] pattern;
		logic [7:0] led_exp;
		logic [1:0] pressed;
		power_lit = led_src.power[1] ? led_src.power[0] : 1'b1;
		pattern   = {3'b000, power_lit, 1'b0, led_src.disk[0], 1'b0, led_src.user};
		for (int i = 0; i < 8; i++)
			led_exp[i] = m_led[8 + i] ? m_led[i] : pattern[i];
		if (valid) begin
			check_value("io_ack", clk_q[3], io_ack);
			check_value("btn_user", deb_level[1], btn_user);
			check_value("btn_osd", deb_level[0], btn_osd);
			check_value("audio_l", m_out_l, audio_l);
			check_value("audio_r", m_out_r, audio_r);
			check_value("cfg", m_cfg, cfg);
			check_value("timing", {m_tim[0], m_tim[1], m_tim[2], m_tim[3], m_tim[4],
				m_tim[5], m_tim[6], m_tim[7]}, timing);
			check_value("led_power", power_lit, led_power);
			check_value("led_hdd", led_src.disk[0], led_hdd);
			check_value("led_user", led_src.user, led_user);
			check_value("led", led_exp, led);
		end
		if (resetd) begin
			valid     = 1'b1;
			clk_q     = '0;
			m_pending = 1'b0;
			m_cmd     = 8'h00;
			m_cnt     = 0;
			m_cfg     = '0;
			m_tim     = '{12'(`SYS_RST_WIDTH), 12'(`SYS_RST_HFP), 12'(`SYS_RST_HS),
				12'(`SYS_RST_HBP), 12'(`SYS_RST_HEIGHT), 12'(`SYS_RST_VFP),
				12'(`SYS_RST_VS), 12'(`SYS_RST_VBP)};
			m_led     = '0;
			m_vol     = '0;
			m_mix_l   = '0;
			m_mix_r   = '0;
			m_mix_sgn = 1'b0;
			m_out_l   = '0;
			m_out_r   = '0;
			deb_cnt   = 0;
			deb_hist  = '{8'h00, 8'h00};
			deb_level = '0;
		end else begin
			// Output stage uses the volume held before this edge
			m_out_l = m_vol[4] ? 16'h0000 : shift_right(m_mix_l, m_vol[3:0], m_mix_sgn);
			m_out_r = m_vol[4] ? 16'h0000 : shift_right(m_mix_r, m_vol[3:0], m_mix_sgn);
			m_mix_l = mix_channel(audio_src.left, audio_src.right, audio_src.mix,
				audio_src.is_signed);
			m_mix_r = mix_channel(audio_src.right, audio_src.left, audio_src.mix,
				audio_src.is_signed);
			m_mix_sgn = audio_src.is_signed;
			// Rising toggle seen past the two synchronizer flops
			if (!host.uio) begin
				m_pending = 1'b0;
			end else if (clk_q[1] && !clk_q[2]) begin
				if (!m_pending) begin
					m_pending = 1'b1;
					m_cmd     = host.din[7:0];
					m_cnt     = 0;
				end else begin
					case (m_cmd)
						CMD_CFG: m_cfg = {host.din[7:5], host.din[3:2], 1'b1};
						CMD_TIMING: begin
							if (m_cnt < 8) begin
								m_tim[m_cnt] = host.din[11:0];
								m_cnt++;
							end
						end
						CMD_LED: m_led = host.din;
						CMD_VOL: m_vol = host.din[4:0];
						default: ;
					endcase
				end
			end
			pressed = {!btn_user_n || !key[1], !btn_osd_n || !key[0]};
			if (deb_cnt == 0) begin
				for (int i = 0; i < 2; i++) begin
					if (deb_hist[i] == 8'hff)
						deb_level[i] = 1'b1;
					else if (deb_hist[i] == 8'h00)
						deb_level[i] = 1'b0;
					deb_hist[i] = {deb_hist[i][6:0], pressed[i]};
				end
			end
			deb_cnt = (deb_cnt == DEB_DIV) ? 0 : deb_cnt + 1;
			clk_q   = {clk_q[2:0], host.clk};
		end
	end

	// ============================================================
	// Host port driver
	// ============================================================

	task automatic wait_ack();
		int n;
		n = 0;
		do begin
			@(negedge FPGA_CLK2_50);
			n++;
			if (n > 16) begin
				$display("io_ack did not follow the host clk line within 16 cycles");
				$display("Verification failed");
				$fatal(1);
			end
		end while (io_ack !== host.clk);
	endtask

	task automatic send_word(input logic [15:0] w);
		@(posedge FPGA_CLK2_50);
		host.din <= w;
		@(posedge FPGA_CLK2_50);
		host.clk <= 1'b1;
		wait_ack();
		@(posedge FPGA_CLK2_50);
		host.clk <= 1'b0;
		wait_ack();
	endtask

	// Opcode and data words with the data now and then cut short by dropping uio
	task automatic send_command(input logic [7:0] op, input int words,
		input logic [15:0] mask);
		int cut;
		cut = ($urandom % 4 == 0) ? $urandom % words : words;
		@(posedge FPGA_CLK2_50);
		host.uio <= 1'b1;
		send_word({8'($urandom), op});
		for (int i = 0; i < cut; i++)
			send_word(16'($urandom) & mask);
		@(posedge FPGA_CLK2_50);
		host.uio <= 1'b0;
		repeat (2) @(posedge FPGA_CLK2_50);
	endtask

	initial begin
		int         sel;
		logic [3:0] r;
		void'($urandom(32'hb3d2d9b4));
		resetd     = 1'b1;
		host       = '{uio: 1'b0, clk: 1'b0, din: 16'h0000};
		btn_user_n = 1'b1;
		btn_osd_n  = 1'b1;
		key        = 2'b11;
		audio_src  = '0;
		led_src    = '{user: 1'b0, power: 2'b10, disk: 2'b00};
		repeat (8) @(posedge FPGA_CLK2_50);
		resetd <= 1'b0;
		@(negedge FPGA_CLK2_50);
		check_value("io_ack", 1'b0, io_ack);
		check_value("btn_user", 1'b0, btn_user);
		check_value("btn_osd", 1'b0, btn_osd);
		check_value("cfg", 6'h00, cfg);
		check_value("led", 8'h00, led);
		check_value("audio_l", 16'h0000, audio_l);
		check_value("audio_r", 16'h0000, audio_r);
		check_value("timing", {12'(`SYS_RST_WIDTH), 12'(`SYS_RST_HFP), 12'(`SYS_RST_HS),
			12'(`SYS_RST_HBP), 12'(`SYS_RST_HEIGHT), 12'(`SYS_RST_VFP),
			12'(`SYS_RST_VS), 12'(`SYS_RST_VBP)}, timing);

		test_name = "host";
		repeat (40) begin
			sel = $urandom % 5;
			case (sel)
				0: send_command(CMD_CFG, 1 + $urandom % 2, 16'hffff);
				1: send_command(CMD_TIMING, 1 + $urandom % 10, 16'hffff);
				2: send_command(CMD_LED, 1, 16'hffff);
				3: send_command(CMD_VOL, 1, 16'hffff);
				default: send_command(8'h40 + 8'($urandom % 32), 2, 16'hffff);
			endcase
		end

		test_name = "audio";
		fork
			repeat (400) begin
				@(posedge FPGA_CLK2_50);
				audio_src <= audio_in_t'({$urandom, 3'($urandom)});
			end
			// Mute bit left random on about one command in four
			repeat (12) send_command(CMD_VOL, 1, ($urandom % 4 == 0) ? 16'hffff : 16'hffef);
		join

		test_name = "led";
		fork
			repeat (200) begin
				@(posedge FPGA_CLK2_50);
				led_src <= led_src_t'(5'($urandom));
			end
			repeat (6) send_command(CMD_LED, 1, 16'hffff);
		join

		test_name = "button";
		repeat (60) begin
			@(posedge FPGA_CLK2_50);
			r = 4'($urandom);
			btn_user_n <= !(r[0] && r[1]);
			key[1]     <= !(r[0] && !r[1]);
			btn_osd_n  <= !(r[2] && r[3]);
			key[0]     <= !(r[2] && !r[3]);
			// Runs of 1 to 12 slow ticks
			repeat ((1 + $urandom % 12) * (DEB_DIV + 1) - 1) @(posedge FPGA_CLK2_50);
		end

		repeat (10) @(negedge FPGA_CLK2_50);
		$display("Verification passed");
		$finish;
	end

endmodule

// File: sys_core.f
+incdir+hw
hw/sys_pkg.sv
hw/btn_debounce.sv
hw/host_io_decoder.sv
hw/audio_mixer.sv
hw/led_driver.sv
hw/sys_core.sv
verification/sys_core_tb.sv

// File: Bender.yml
package:
  name: sys_core

sources:
  - include_dirs:
      - hw
    files:
      - hw/sys_pkg.sv
      - hw/btn_debounce.sv
      - hw/host_io_decoder.sv
      - hw/audio_mixer.sv
      - hw/led_driver.sv
      - hw/sys_core.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - verification/sys_core_tb.sv
